// ==== rtl/alu.sv ====
//**************************************************************************
// Arithmetic and logic unit
// Combinational result with registered carry and zero flags
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module alu (
   input  logic             cp2,
   input  logic             ireset,
   input  logic             alu_en,
   input  avr_pkg::alu_op_t alu_op,
   input  logic [7:0]       rd_val,
   input  logic [7:0]       rr_val,
   input  logic [7:0]       imm,
   output logic [7:0]       alu_res,
   output logic             flag_c,
   output logic             flag_z
);

   logic [8:0] sum;                            // Bit 8 is the carry
   logic [8:0] diff;                           // Bit 8 is the borrow

   assign sum  = {1'b0, rd_val} + {1'b0, rr_val};
   assign diff = {1'b0, rd_val} - {1'b0, rr_val};

   always_comb
   begin
      case (alu_op)
         avr_pkg::ALU_ADD:      alu_res = sum[7:0];
         avr_pkg::ALU_SUB:      alu_res = diff[7:0];
         avr_pkg::ALU_AND:      alu_res = rd_val & rr_val;
         avr_pkg::ALU_EOR:      alu_res = rd_val ^ rr_val;
         avr_pkg::ALU_PASS_IMM: alu_res = imm;
         default:               alu_res = rr_val;   // MOV, MOVW
      endcase
   end

   //**************************************************************************
   // Status flags
   //**************************************************************************
   always_ff @(posedge cp2 or negedge ireset)
   begin
      if (!ireset)
      begin
         flag_c <= 1'b0;
         flag_z <= 1'b0;
      end
      else if (alu_en)
      begin
         case (alu_op)
            avr_pkg::ALU_ADD:
            begin
               flag_c <= sum[8];
               flag_z <= (sum[7:0] == 8'h00);
            end
            avr_pkg::ALU_SUB:
            begin
               flag_c <= diff[8];
               flag_z <= (diff[7:0] == 8'h00);
            end
            avr_pkg::ALU_AND, avr_pkg::ALU_EOR:
               flag_z <= (alu_res == 8'h00);   // C kept
            default: ;                         // Moves keep both flags
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== rtl/avr_exec_top.sv ====
//**************************************************************************
// AVR execution slice top level
// Decoder, register file, ALU and data RAM on one instruction strobe
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module avr_exec_top (
   input  logic        cp2,
   input  logic        ireset,
   input  logic        instr_valid,
   input  logic [15:0] instr,
   input  logic [4:0]  obs_adr,
   output logic [7:0]  obs_data,
   output logic        flag_c,
   output logic        flag_z,
   output logic        illegal
);

   logic [4:0]       rd_adr;
   logic [4:0]       rr_adr;
   logic             rd_wr;
   logic             w_op;
   logic             h_wr;
   logic [2:0]       h_adr;
   logic             post_inc;
   logic             pre_dec;
   logic             wb_ram;
   logic             ram_we;
   avr_pkg::alu_op_t alu_op;
   logic [7:0]       imm;
   logic             alu_en;
   logic [7:0]       rd_out;                   // Also ST write data
   logic [7:0]       rr_out;
   logic [15:0]      h_out;                    // Pointer address
   logic [7:0]       alu_res;
   logic [7:0]       ram_rdata;

   instr_decoder u_dec (
      .instr_valid (instr_valid),
      .instr       (instr),
      .rd_adr      (rd_adr),
      .rr_adr      (rr_adr),
      .rd_wr       (rd_wr),
      .w_op        (w_op),
      .h_wr        (h_wr),
      .h_adr       (h_adr),
      .post_inc    (post_inc),
      .pre_dec     (pre_dec),
      .wb_ram      (wb_ram),
      .ram_we      (ram_we),
      .alu_op      (alu_op),
      .imm         (imm),
      .alu_en      (alu_en),
      .illegal     (illegal)
   );

   reg_file u_rf (
      .cp2       (cp2),
      .cp2en     (instr_valid),                // Strobe is the clock enable
      .ireset    (ireset),
      .rd_adr    (rd_adr),
      .rr_adr    (rr_adr),
      .rd_wr     (rd_wr),
      .w_op      (w_op),
      .post_inc  (post_inc),
      .pre_dec   (pre_dec),
      .h_wr      (h_wr),
      .wb_ram    (wb_ram),                     // Load data select
      .h_adr     (h_adr),
      .alu_res   (alu_res),
      .ram_rdata (ram_rdata),
      .obs_adr   (obs_adr),
      .rd_out    (rd_out),
      .rr_out    (rr_out),
      .rr_hb_out (),
      .obs_data  (obs_data),
      .h_out     (h_out)
   );

   alu u_alu (
      .cp2     (cp2),
      .ireset  (ireset),
      .alu_en  (alu_en),
      .alu_op  (alu_op),
      .rd_val  (rd_out),
      .rr_val  (rr_out),
      .imm     (imm),
      .alu_res (alu_res),
      .flag_c  (flag_c),
      .flag_z  (flag_z)
   );

   data_ram u_ram (
      .cp2   (cp2),
      .we    (ram_we),
      .adr   (h_out[avr_pkg::RAM_ADR_W-1:0]),  // Low pointer bits
      .wdata (rd_out),
      .rdata (ram_rdata)
   );

endmodule

`default_nettype wire

// ==== rtl/avr_pkg.sv ====
//**************************************************************************
// AVR execution slice shared definitions
// Sizes, pointer selects, ALU operation codes, opcode constants and
// the two decode views of the 16-bit instruction word
//**************************************************************************

`default_nettype none

package avr_pkg;

   // Sizes and addresses
   localparam int GPR_COUNT = 32;              // General purpose registers
   localparam int RAM_DEPTH = 64;              // Data memory bytes
   localparam int RAM_ADR_W = 6;               // Low bits of the pointer
   localparam int X_LO      = 26;              // XL
   localparam int X_HI      = 27;              // XH

   // One-hot pointer select
   localparam logic [2:0] PTR_X = 3'b001;
   localparam logic [2:0] PTR_Y = 3'b010;
   localparam logic [2:0] PTR_Z = 3'b100;

   typedef enum logic [2:0] {
      ALU_ADD,                                 // Rd + Rr
      ALU_SUB,                                 // Rd - Rr
      ALU_AND,                                 // Rd & Rr
      ALU_EOR,                                 // Rd ^ Rr
      ALU_PASS_RR,                             // MOV and MOVW
      ALU_PASS_IMM                             // LDI
   } alu_op_t;

   // Register format, used by ALU ops, MOVW and LD/ST
   typedef struct packed {
      logic [5:0] opcode;
      logic       r_hi;                        // Rr bit 4
      logic [4:0] d;
      logic [3:0] r_lo;                        // Rr bits 3..0, or LD/ST mode
   } reg_fmt_t;

   // Immediate format, used by LDI
   typedef struct packed {
      logic [3:0] opcode;
      logic [3:0] k_hi;
      logic [3:0] d;                           // R16..R31 offset
      logic [3:0] k_lo;
   } imm_fmt_t;

   typedef union packed {
      reg_fmt_t r;
      imm_fmt_t i;
   } instr_t;

   // 6-bit opcodes of the register format
   localparam logic [5:0] OPC_ADD = 6'b000011;
   localparam logic [5:0] OPC_SUB = 6'b000110;
   localparam logic [5:0] OPC_AND = 6'b001000;
   localparam logic [5:0] OPC_EOR = 6'b001001;
   localparam logic [5:0] OPC_MOV = 6'b001011;

   localparam logic [3:0] OPC_LDI  = 4'b1110;
   localparam logic [7:0] OPC_MOVW = 8'b0000_0001;

   // 7-bit prefixes of LD Rd,X and ST X,Rr
   localparam logic [6:0] OPC_LD = 7'b1001_000;
   localparam logic [6:0] OPC_ST = 7'b1001_001;

   localparam logic [3:0] MODE_POSTINC = 4'b1101;   // X+
   localparam logic [3:0] MODE_PREDEC  = 4'b1110;   // -X

endpackage

`default_nettype wire

// ==== rtl/data_ram.sv ====
//**************************************************************************
// Data memory
// 64 bytes, asynchronous read and write on the rising clock edge
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module data_ram (
   input  logic                          cp2,
   input  logic                          we,
   input  logic [avr_pkg::RAM_ADR_W-1:0] adr,
   input  logic [7:0]                    wdata,
   output logic [7:0]                    rdata
);

   logic [7:0] mem [avr_pkg::RAM_DEPTH];       // Contents not initialised

   always_ff @(posedge cp2)
   begin
      if (we)
         mem[adr] <= wdata;                    // ST
   end

   assign rdata = mem[adr];                    // LD data in the same cycle

endmodule

`default_nettype wire

// ==== rtl/instr_decoder.sv ====
//**************************************************************************
// Instruction decoder
// Splits the instruction word into register addresses, ALU control,
// pointer control and write enables gated by the valid strobe
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
   input  logic             instr_valid,
   input  logic [15:0]      instr,
   output logic [4:0]       rd_adr,
   output logic [4:0]       rr_adr,
   output logic             rd_wr,
   output logic             w_op,
   output logic             h_wr,
   output logic [2:0]       h_adr,
   output logic             post_inc,
   output logic             pre_dec,
   output logic             wb_ram,
   output logic             ram_we,
   output avr_pkg::alu_op_t alu_op,
   output logic [7:0]       imm,
   output logic             alu_en,
   output logic             illegal
);

   avr_pkg::instr_t iw;
   logic [6:0] pfx7;                           // LD/ST prefix
   logic [7:0] pfx8;                           // MOVW prefix
   logic       mode_ok;
   logic       known;
   logic       dec_rd_wr;
   logic       dec_h_wr;
   logic       dec_ram_we;
   logic       dec_alu_en;

   assign iw      = instr;
   assign pfx7    = {iw.r.opcode, iw.r.r_hi};
   assign pfx8    = {iw.r.opcode, iw.r.r_hi, iw.r.d[4]};
   assign mode_ok = (iw.r.r_lo == avr_pkg::MODE_POSTINC) ||
                    (iw.r.r_lo == avr_pkg::MODE_PREDEC);
   assign imm     = {iw.i.k_hi, iw.i.k_lo};

   //**************************************************************************
   // Opcode match
   //**************************************************************************
   always_comb
   begin
      known      = 1'b1;
      rd_adr     = iw.r.d;                     // Rd, or Rr for ST
      rr_adr     = {iw.r.r_hi, iw.r.r_lo};
      alu_op     = avr_pkg::ALU_PASS_RR;
      dec_rd_wr  = 1'b0;
      dec_alu_en = 1'b0;
      dec_h_wr   = 1'b0;
      dec_ram_we = 1'b0;
      w_op       = 1'b0;
      wb_ram     = 1'b0;
      h_adr      = 3'b000;
      post_inc   = (iw.r.r_lo == avr_pkg::MODE_POSTINC);
      pre_dec    = (iw.r.r_lo == avr_pkg::MODE_PREDEC);
      if (iw.r.opcode == avr_pkg::OPC_ADD || iw.r.opcode == avr_pkg::OPC_SUB ||
          iw.r.opcode == avr_pkg::OPC_AND || iw.r.opcode == avr_pkg::OPC_EOR ||
          iw.r.opcode == avr_pkg::OPC_MOV)
      begin
         dec_rd_wr  = 1'b1;
         dec_alu_en = 1'b1;
         case (iw.r.opcode)
            avr_pkg::OPC_ADD: alu_op = avr_pkg::ALU_ADD;
            avr_pkg::OPC_SUB: alu_op = avr_pkg::ALU_SUB;
            avr_pkg::OPC_AND: alu_op = avr_pkg::ALU_AND;
            avr_pkg::OPC_EOR: alu_op = avr_pkg::ALU_EOR;
            default:          alu_op = avr_pkg::ALU_PASS_RR;   // MOV
         endcase
      end
      else if (iw.i.opcode == avr_pkg::OPC_LDI)
      begin
         rd_adr     = {1'b1, iw.i.d};          // R16..R31
         alu_op     = avr_pkg::ALU_PASS_IMM;
         dec_rd_wr  = 1'b1;
         dec_alu_en = 1'b1;
      end
      else if (pfx8 == avr_pkg::OPC_MOVW)
      begin
         rd_adr     = {iw.r.d[3:0], 1'b0};     // Even register of each pair
         rr_adr     = {iw.r.r_lo, 1'b0};
         w_op       = 1'b1;
         dec_rd_wr  = 1'b1;
         dec_alu_en = 1'b1;
      end
      else if (pfx7 == avr_pkg::OPC_LD && mode_ok)
      begin
         h_adr      = avr_pkg::PTR_X;
         dec_h_wr   = 1'b1;
         dec_rd_wr  = 1'b1;
         wb_ram     = 1'b1;                    // Load data into Rd
      end
      else if (pfx7 == avr_pkg::OPC_ST && mode_ok)
      begin
         h_adr      = avr_pkg::PTR_X;
         dec_h_wr   = 1'b1;
         dec_ram_we = 1'b1;
      end
      else
         known = 1'b0;                         // Nothing gets written
   end

   // Strobe gating
   assign rd_wr   = instr_valid & dec_rd_wr;
   assign h_wr    = instr_valid & dec_h_wr;
   assign ram_we  = instr_valid & dec_ram_we;
   assign alu_en  = instr_valid & dec_alu_en;
   assign illegal = instr_valid & ~known;

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
//**************************************************************************
// General purpose register file
// 32 x 8 registers with X/Y/Z pointer update, word write and a
// write-back select between ALU and RAM data
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module reg_file (
   input  logic        cp2,
   input  logic        cp2en,
   input  logic        ireset,
   input  logic [4:0]  rd_adr,
   input  logic [4:0]  rr_adr,
   input  logic        rd_wr,
   input  logic        w_op,
   input  logic        post_inc,
   input  logic        pre_dec,
   input  logic        h_wr,
   input  logic        wb_ram,
   input  logic [2:0]  h_adr,
   input  logic [7:0]  alu_res,
   input  logic [7:0]  ram_rdata,
   input  logic [4:0]  obs_adr,
   output logic [7:0]  rd_out,
   output logic [7:0]  rr_out,
   output logic [7:0]  rr_hb_out,
   output logic [7:0]  obs_data,
   output logic [15:0] h_out
);

   logic [7:0]  gprf [avr_pkg::GPR_COUNT];
   logic [7:0]  rd_in;                         // Write-back data
   logic [4:0]  rd_hb_idx;                     // Odd register of the pair
   logic [4:0]  rr_hb_idx;
   logic [15:0] h_cur;                         // Selected pointer
   logic [15:0] h_inc;
   logic [15:0] h_dec;
   logic [15:0] h_in;                          // Updated pointer

   assign rd_in     = wb_ram ? ram_rdata : alu_res;
   assign rd_hb_idx = rd_adr + 5'd1;
   assign rr_hb_idx = rr_adr + 5'd1;

   //**************************************************************************
   // Pointer select and update
   //**************************************************************************
   always_comb
   begin
      case (h_adr)
         avr_pkg::PTR_X: h_cur = {gprf[avr_pkg::X_HI], gprf[avr_pkg::X_LO]};
         avr_pkg::PTR_Y: h_cur = {gprf[avr_pkg::X_HI + 2], gprf[avr_pkg::X_LO + 2]};
         avr_pkg::PTR_Z: h_cur = {gprf[avr_pkg::X_HI + 4], gprf[avr_pkg::X_LO + 4]};
         default:        h_cur = 16'h0000;
      endcase
   end

   assign h_inc = h_cur + 16'd1;               // Wraps at 16 bits
   assign h_dec = h_cur - 16'd1;
   assign h_out = pre_dec ? h_dec : h_cur;     // -X addresses X-1
   assign h_in  = post_inc ? h_inc : h_dec;

   //**************************************************************************
   // Register array
   //**************************************************************************
   always_ff @(posedge cp2 or negedge ireset)
   begin
      if (!ireset)
      begin
         for (int i = 0; i < avr_pkg::GPR_COUNT; i++)
            gprf[i] <= 8'h00;
      end
      else if (cp2en)
      begin
         if (h_wr)                             // Pointer first, Rd overrides
         begin
            case (h_adr)
               avr_pkg::PTR_X:
               begin
                  gprf[avr_pkg::X_LO] <= h_in[7:0];
                  gprf[avr_pkg::X_HI] <= h_in[15:8];
               end
               avr_pkg::PTR_Y:
               begin
                  gprf[avr_pkg::X_LO + 2] <= h_in[7:0];
                  gprf[avr_pkg::X_HI + 2] <= h_in[15:8];
               end
               avr_pkg::PTR_Z:
               begin
                  gprf[avr_pkg::X_LO + 4] <= h_in[7:0];
                  gprf[avr_pkg::X_HI + 4] <= h_in[15:8];
               end
               default: ;                      // No pointer selected
            endcase
         end
         if (rd_wr)
         begin
            gprf[rd_adr] <= rd_in;
            if (w_op)
               gprf[rd_hb_idx] <= rr_hb_out;   // MOVW high byte
         end
      end
   end

   // Read ports
   assign rd_out    = gprf[rd_adr];
   assign rr_out    = gprf[rr_adr];
   assign rr_hb_out = gprf[rr_hb_idx];
   assign obs_data  = gprf[obs_adr];           // Debug view

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build the AVR execution slice testbench with Verilator and run it.
# The result is decided by the pass line in sim.log.

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_avr_exec \
   -Mdir obj_dir -o sim_avr_exec \
   && ./obj_dir/sim_avr_exec > sim.log 2>&1 \
   || echo "Build or simulation did not complete"

cat sim.log 2>/dev/null

grep -qx "TEST OK" sim.log 2>/dev/null \
   && echo "Simulation passed" \
   || { echo "Simulation failed, see sim.log"; exit 1; }

// ==== sim.f ====
rtl/avr_pkg.sv
rtl/instr_decoder.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/data_ram.sv
rtl/avr_exec_top.sv
verification/tb_avr_exec.sv

// ==== verification/tb_avr_exec.sv ====
//**************************************************************************
// Testbench for the AVR execution slice
// Reference model of registers, RAM and flags, checked every cycle by
// concurrent assertions while directed and random programs run
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module tb_avr_exec;

   localparam int MAX_CYCLES = 200 * 34 + 500;   // Instructions x sweep length
   localparam int K_ADD  = 0;
   localparam int K_SUB  = 1;
   localparam int K_AND  = 2;
   localparam int K_EOR  = 3;
   localparam int K_MOV  = 4;
   localparam int K_LDI  = 5;
   localparam int K_MOVW = 6;
   localparam int K_LD   = 7;
   localparam int K_ST   = 8;
   localparam int K_BAD  = 9;

   logic        cp2 = 1'b0;
   logic        ireset;
   logic        instr_valid;
   logic [15:0] instr;
   logic [4:0]  obs_adr;
   logic [7:0]  obs_data;
   logic        flag_c;
   logic        flag_z;
   logic        illegal;

   logic [7:0]  m_gpr [32];                    // Model registers
   logic [7:0]  m_ram [64];                    // Model data memory
   logic        m_c;
   logic        m_z;
   int          seed;
   int          cycles = 0;
   int          reg_errs = 0;
   int          flag_errs = 0;
   int          ill_errs = 0;

   avr_exec_top u_dut (
      .cp2         (cp2),
      .ireset      (ireset),
      .instr_valid (instr_valid),
      .instr       (instr),
      .obs_adr     (obs_adr),
      .obs_data    (obs_data),
      .flag_c      (flag_c),
      .flag_z      (flag_z),
      .illegal     (illegal)
   );

   always #4 cp2 = ~cp2;                       // 8 ns period

   //**************************************************************************
   // Encoding helpers
   //**************************************************************************
   function automatic logic [15:0] rand16();
      int v;
      v = $random(seed);
      return v[15:0];
   endfunction

   function automatic logic [15:0] enc_rr(input logic [5:0] opc, input logic [4:0] d,
                                          input logic [4:0] r);
      return {opc, r[4], d, r[3:0]};
   endfunction

   function automatic logic [15:0] enc_ldi(input logic [4:0] d, input logic [7:0] k);
      return {avr_pkg::OPC_LDI, k[7:4], d[3:0], k[3:0]};   // d is R16..R31
   endfunction

   function automatic logic [15:0] enc_movw(input logic [4:0] d, input logic [4:0] r);
      return {avr_pkg::OPC_MOVW, d[4:1], r[4:1]};
   endfunction

   function automatic logic [15:0] enc_ptr(input logic [6:0] pfx, input logic [4:0] ri,
                                           input logic [3:0] mode);
      return {pfx, ri, mode};                  // LD Rd or ST Rr through X
   endfunction

   function automatic logic [5:0] alu_opc(input logic [2:0] s);
      case (s)
         3'd1, 3'd6: return avr_pkg::OPC_SUB;
         3'd2, 3'd7: return avr_pkg::OPC_AND;
         3'd3:       return avr_pkg::OPC_EOR;
         3'd4:       return avr_pkg::OPC_MOV;
         default:    return avr_pkg::OPC_ADD;
      endcase
   endfunction

   // Instruction class from the encoding rules
   function automatic int classify(input logic [15:0] w);
      logic mode_ok;
      mode_ok = (w[3:0] == avr_pkg::MODE_POSTINC) || (w[3:0] == avr_pkg::MODE_PREDEC);
      if (w[15:10] == avr_pkg::OPC_ADD) return K_ADD;
      if (w[15:10] == avr_pkg::OPC_SUB) return K_SUB;
      if (w[15:10] == avr_pkg::OPC_AND) return K_AND;
      if (w[15:10] == avr_pkg::OPC_EOR) return K_EOR;
      if (w[15:10] == avr_pkg::OPC_MOV) return K_MOV;
      if (w[15:12] == avr_pkg::OPC_LDI) return K_LDI;
      if (w[15:8] == avr_pkg::OPC_MOVW) return K_MOVW;
      if (w[15:9] == avr_pkg::OPC_LD && mode_ok) return K_LD;
      if (w[15:9] == avr_pkg::OPC_ST && mode_ok) return K_ST;
      return K_BAD;
   endfunction

   //**************************************************************************
   // Reference model, commits on the same edge as the DUT
   //**************************************************************************
   always @(posedge cp2 or negedge ireset)
   begin : ref_model
      logic [7:0]  a;
      logic [7:0]  b;
      int          total;
      logic [15:0] x;
      logic [15:0] x_new;
      logic [15:0] adr;
      logic [4:0]  d;
      logic [4:0]  r;
      if (!ireset)
      begin
         for (int i = 0; i < 32; i++)
            m_gpr[i] <= 8'h00;
         m_c <= 1'b0;
         m_z <= 1'b0;
      end
      else if (instr_valid)
      begin
         d     = instr[8:4];
         r     = {instr[9], instr[3:0]};
         a     = m_gpr[d];
         b     = m_gpr[r];
         x     = {m_gpr[27], m_gpr[26]};
         total = int'(a) + int'(b);            // Unsigned sum up to 510
         x_new = (instr[3:0] == avr_pkg::MODE_PREDEC) ? x - 16'd1 : x + 16'd1;
         adr   = (instr[3:0] == avr_pkg::MODE_PREDEC) ? x - 16'd1 : x;
         case (classify(instr))
            K_ADD:
            begin
               m_gpr[d] <= total % 256;
               m_c      <= (total > 255);     // Carry out of bit 7
               m_z      <= (total % 256 == 0);
            end
            K_SUB:
            begin
               m_gpr[d] <= a - b;
               m_c      <= (a < b);           // Borrow
               m_z      <= (a == b);
            end
            K_AND:
            begin
               m_gpr[d] <= a & b;
               m_z      <= ((a & b) == 8'h00);
            end
            K_EOR:
            begin
               m_gpr[d] <= a ^ b;
               m_z      <= ((a ^ b) == 8'h00);
            end
            K_MOV: m_gpr[d] <= b;
            K_LDI: m_gpr[{1'b1, instr[7:4]}] <= {instr[11:8], instr[3:0]};
            K_MOVW:
            begin
               m_gpr[{instr[7:4], 1'b0}] <= m_gpr[{instr[3:0], 1'b0}];
               m_gpr[{instr[7:4], 1'b1}] <= m_gpr[{instr[3:0], 1'b1}];
            end
            K_LD:
            begin
               m_gpr[26] <= x_new[7:0];
               m_gpr[27] <= x_new[15:8];
               m_gpr[d]  <= m_ram[adr[5:0]];   // Rd wins over X
            end
            K_ST:
            begin
               m_gpr[26]        <= x_new[7:0];
               m_gpr[27]        <= x_new[15:8];
               m_ram[adr[5:0]]  <= a;          // d field holds Rr
            end
            default: ;                         // Unknown opcode
         endcase
      end
   end

   //**************************************************************************
   // Checks
   //**************************************************************************
   chk_regs: assert property (@(posedge cp2) disable iff (!ireset)
                              obs_data == m_gpr[obs_adr])
      else
      begin
         $display("error: %0t R%0d reads %h, expected %h", $time, $sampled(obs_adr),
                  $sampled(obs_data), $sampled(m_gpr[obs_adr]));
         reg_errs++;
      end

   chk_flags: assert property (@(posedge cp2) disable iff (!ireset)
                               flag_c == m_c && flag_z == m_z)
      else
      begin
         $display("error: %0t flags C=%b Z=%b, expected C=%b Z=%b", $time,
                  $sampled(flag_c), $sampled(flag_z), $sampled(m_c), $sampled(m_z));
         flag_errs++;
      end

   chk_illegal: assert property (@(posedge cp2) disable iff (!ireset)
                                 illegal == (instr_valid && classify(instr) == K_BAD))
      else
      begin
         $display("error: %0t illegal is %b for instr %h, valid %b", $time,
                  $sampled(illegal), $sampled(instr), $sampled(instr_valid));
         ill_errs++;
      end

   //**************************************************************************
   // Stimulus
   //**************************************************************************
   task automatic sweep_regs();
      for (int i = 0; i < 32; i++)
      begin
         @(posedge cp2);
         obs_adr <= i[4:0];
      end
      @(posedge cp2);                          // Last address gets checked
   endtask

   task automatic issue(input logic [15:0] w);
      @(posedge cp2);
      instr_valid <= 1'b1;
      instr       <= w;
      @(posedge cp2);                          // Commit edge
      instr_valid <= 1'b0;
      sweep_regs();
   endtask

   function automatic logic [15:0] random_instr();
      logic [15:0] s;
      logic [15:0] v;
      s = rand16();
      v = rand16();
      case (s[2:0])
         3'd5:    return enc_ldi({1'b1, s[6:3]}, v[7:0]);
         3'd6:    return enc_movw(s[7:3], v[4:0]);
         3'd7:    return s[3] ? 16'hFFFF : enc_ptr(avr_pkg::OPC_ST, s[8:4],
                                                   avr_pkg::MODE_POSTINC);
         default: return enc_rr(alu_opc(s[2:0]), s[8:4], v[4:0]);
      endcase
   endfunction

   task automatic run_burst(input int n);
      logic [15:0] s;
      for (int i = 0; i < n; i++)
      begin
         @(posedge cp2);
         s           = rand16();
         instr_valid <= 1'b1;                  // Every cycle
         instr       <= random_instr();
         obs_adr     <= s[4:0];
      end
      @(posedge cp2);
      instr_valid <= 1'b0;
      sweep_regs();
   endtask

   // Cycle limit
   always @(posedge cp2)
   begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES)
      begin
         $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         $display("TEST FAILED");
         $finish;
      end
   end

   initial
   begin
      logic [15:0] v;
      seed        = 32'hb54b_a1a1;
      ireset      = 1'b0;
      instr_valid = 1'b0;
      instr       = 16'h0000;
      obs_adr     = 5'd0;
      repeat (2) @(posedge cp2);
      ireset <= 1'b1;
      sweep_regs();                            // Reset state

      // LDI then ALU sequences
      for (int i = 0; i < 16; i++)
      begin
         v = rand16();
         issue(enc_ldi({1'b1, i[3:0]}, v[7:0]));
      end
      issue(enc_ldi(5'd16, 8'hF0));
      issue(enc_ldi(5'd17, 8'h20));
      issue(enc_rr(avr_pkg::OPC_ADD, 5'd16, 5'd17));   // Carry out
      issue(enc_rr(avr_pkg::OPC_EOR, 5'd18, 5'd18));   // Z set, C kept
      issue(enc_rr(avr_pkg::OPC_SUB, 5'd16, 5'd17));   // Borrow
      issue(enc_rr(avr_pkg::OPC_AND, 5'd19, 5'd20));
      for (int n = 0; n < 40; n++)
      begin
         v = rand16();
         issue(enc_rr(alu_opc(v[2:0]), v[7:3], v[12:8]));
      end

      // Word moves
      issue(enc_movw(5'd0, 5'd16));
      issue(enc_movw(5'd30, 5'd20));
      issue(enc_movw(5'd8, 5'd22));

      // Stores and loads through X
      issue(enc_ldi(5'd26, 8'h10));
      issue(enc_ldi(5'd27, 8'h00));
      for (int i = 0; i < 4; i++)
         issue(enc_ptr(avr_pkg::OPC_ST, 5'd16 + i[4:0], avr_pkg::MODE_POSTINC));
      for (int i = 0; i < 4; i++)
         issue(enc_ptr(avr_pkg::OPC_LD, i[4:0], avr_pkg::MODE_PREDEC));
      issue(enc_ptr(avr_pkg::OPC_ST, 5'd20, avr_pkg::MODE_PREDEC));
      issue(enc_ptr(avr_pkg::OPC_LD, 5'd5, avr_pkg::MODE_POSTINC));
      issue(enc_ldi(5'd26, 8'h00));            // X = 0000
      issue(enc_ptr(avr_pkg::OPC_ST, 5'd21, avr_pkg::MODE_PREDEC));   // Wraps to FFFF
      issue(enc_ptr(avr_pkg::OPC_LD, 5'd6, avr_pkg::MODE_POSTINC));   // Back to 0000

      // Unknown opcodes
      issue(16'hFFFF);
      issue(16'h9000);                         // LD with a bad mode
      issue(16'h0000);

      run_burst(120);

      $display("Errors: registers %0d, flags %0d, illegal %0d",
               reg_errs, flag_errs, ill_errs);
      if (reg_errs + flag_errs + ill_errs == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire
